// File: riscv_isa_pkg.sv
package riscv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [4:0] alu_op_t;

  localparam int num_regs = 32;

  // major opcodes handled by the core
  localparam opcode_t op_lui     = 7'b01_101_11;
  localparam opcode_t op_jal     = 7'b11_011_11;
  localparam opcode_t op_jalr    = 7'b11_001_11;
  localparam opcode_t op_branch  = 7'b11_000_11;
  localparam opcode_t op_reg_imm = 7'b00_100_11;
  localparam opcode_t op_reg_reg = 7'b01_100_11;
  localparam opcode_t op_environ = 7'b11_100_11;

  // funct3 of the arithmetic group
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct3 of the conditional branches
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // alt selects sub and sra
  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_alt  = 7'b0100000;

  // compact operation codes, decoded once in decode
  localparam alu_op_t alu_nop   = 5'd0;
  localparam alu_op_t alu_add   = 5'd1;
  localparam alu_op_t alu_sub   = 5'd2;
  localparam alu_op_t alu_sll   = 5'd3;
  localparam alu_op_t alu_slt   = 5'd4;
  localparam alu_op_t alu_sltu  = 5'd5;
  localparam alu_op_t alu_xor   = 5'd6;
  localparam alu_op_t alu_srl   = 5'd7;
  localparam alu_op_t alu_sra   = 5'd8;
  localparam alu_op_t alu_or    = 5'd9;
  localparam alu_op_t alu_and   = 5'd10;
  localparam alu_op_t alu_lui   = 5'd11;
  localparam alu_op_t alu_jal   = 5'd12;
  localparam alu_op_t alu_jalr  = 5'd13;
  localparam alu_op_t alu_beq   = 5'd14;
  localparam alu_op_t alu_bne   = 5'd15;
  localparam alu_op_t alu_blt   = 5'd16;
  localparam alu_op_t alu_bge   = 5'd17;
  localparam alu_op_t alu_bltu  = 5'd18;
  localparam alu_op_t alu_bgeu  = 5'd19;
  localparam alu_op_t alu_ecall = 5'd20;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

  // what writeback holds in a given cycle, one value at a time
  typedef logic [5:0] cycle_status_t;

  localparam cycle_status_t cycle_invalid      = 6'd0;
  localparam cycle_status_t cycle_reset        = 6'd1;
  localparam cycle_status_t cycle_no_stall     = 6'd2;
  localparam cycle_status_t cycle_taken_branch = 6'd4;

  // pc step between sequential instructions
  localparam riscv_isa_pkg::word_t insn_bytes = 32'd4;

endpackage

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter riscv_isa_pkg::word_t reset_pc = 32'd0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    branch_taken,
  input  riscv_isa_pkg::word_t    branch_target,
  input  riscv_isa_pkg::insn_t    insn_from_imem,
  output riscv_isa_pkg::word_t    pc_to_imem,
  output riscv_isa_pkg::word_t    d_pc,
  output riscv_isa_pkg::insn_t    d_insn,
  output pipe_pkg::cycle_status_t d_status
);

  riscv_isa_pkg::word_t pc;

  // redirect wins over the sequential step
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else begin
      pc <= pc + pipe_pkg::insn_bytes;
    end
  end

  assign pc_to_imem = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= pipe_pkg::cycle_reset;
    end else if (branch_taken) begin
      // wrong-path fetch becomes a bubble
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= pipe_pkg::cycle_taken_branch;
    end else begin
      d_pc     <= pc;
      d_insn   <= insn_from_imem;
      d_status <= pipe_pkg::cycle_no_stall;
    end
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  riscv_isa_pkg::reg_addr_t rs1,
  input  riscv_isa_pkg::reg_addr_t rs2,
  input  riscv_isa_pkg::reg_addr_t rd,
  input  logic                    we,
  input  riscv_isa_pkg::word_t    rd_data,
  output riscv_isa_pkg::word_t    rs1_data,
  output riscv_isa_pkg::word_t    rs2_data
);

  // x0 has no storage
  riscv_isa_pkg::word_t regs [1:riscv_isa_pkg::num_regs-1];

  // decode never raises we for x0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < riscv_isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     branch_taken,
  input  riscv_isa_pkg::word_t     d_pc,
  input  riscv_isa_pkg::insn_t     d_insn,
  input  pipe_pkg::cycle_status_t  d_status,
  input  riscv_isa_pkg::reg_addr_t w_rd,
  input  logic                     w_we,
  input  riscv_isa_pkg::word_t     w_rd_data,
  output riscv_isa_pkg::reg_addr_t rs1,
  output riscv_isa_pkg::reg_addr_t rs2,
  input  riscv_isa_pkg::word_t     rs1_data,
  input  riscv_isa_pkg::word_t     rs2_data,
  output riscv_isa_pkg::word_t     x_pc,
  output riscv_isa_pkg::insn_t     x_insn,
  output riscv_isa_pkg::alu_op_t   x_op,
  output logic                     x_use_imm,
  output riscv_isa_pkg::reg_addr_t x_rs1,
  output riscv_isa_pkg::reg_addr_t x_rs2,
  output riscv_isa_pkg::reg_addr_t x_rd,
  output logic                     x_we,
  output riscv_isa_pkg::word_t     x_rs1_data,
  output riscv_isa_pkg::word_t     x_rs2_data,
  output pipe_pkg::cycle_status_t  x_status
);

  riscv_isa_pkg::opcode_t   opcode;
  riscv_isa_pkg::funct3_t   funct3;
  riscv_isa_pkg::funct7_t   funct7;
  riscv_isa_pkg::reg_addr_t rd;
  riscv_isa_pkg::alu_op_t   arith_op;
  riscv_isa_pkg::alu_op_t   op;
  logic                     alt;
  logic                     funct7_ok;
  logic                     use_imm;
  logic                     writes;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = d_insn;

  assign alt = (funct7 == riscv_isa_pkg::f7_alt);
  // alt is only legal on add/sub and the right shifts
  assign funct7_ok = (funct7 == riscv_isa_pkg::f7_base) ||
                     (alt && (funct3 == riscv_isa_pkg::f3_add_sub ||
                              funct3 == riscv_isa_pkg::f3_srl_sra));

  // shared funct3 map for reg-imm and reg-reg
  always_comb begin
    case (funct3)
      riscv_isa_pkg::f3_add_sub: arith_op = alt ? riscv_isa_pkg::alu_sub : riscv_isa_pkg::alu_add;
      riscv_isa_pkg::f3_sll:     arith_op = riscv_isa_pkg::alu_sll;
      riscv_isa_pkg::f3_slt:     arith_op = riscv_isa_pkg::alu_slt;
      riscv_isa_pkg::f3_sltu:    arith_op = riscv_isa_pkg::alu_sltu;
      riscv_isa_pkg::f3_xor:     arith_op = riscv_isa_pkg::alu_xor;
      riscv_isa_pkg::f3_srl_sra: arith_op = alt ? riscv_isa_pkg::alu_sra : riscv_isa_pkg::alu_srl;
      riscv_isa_pkg::f3_or:      arith_op = riscv_isa_pkg::alu_or;
      default:                   arith_op = riscv_isa_pkg::alu_and;
    endcase
  end

  always_comb begin
    op      = riscv_isa_pkg::alu_nop;
    use_imm = 1'b0;
    writes  = 1'b0;
    case (opcode)
      riscv_isa_pkg::op_lui: begin
        op     = riscv_isa_pkg::alu_lui;
        writes = 1'b1;
      end
      riscv_isa_pkg::op_jal: begin
        op     = riscv_isa_pkg::alu_jal;
        writes = 1'b1;
      end
      riscv_isa_pkg::op_jalr: begin
        op     = (funct3 == '0) ? riscv_isa_pkg::alu_jalr : riscv_isa_pkg::alu_nop;
        writes = 1'b1;
      end
      riscv_isa_pkg::op_branch: begin
        case (funct3)
          riscv_isa_pkg::f3_beq:  op = riscv_isa_pkg::alu_beq;
          riscv_isa_pkg::f3_bne:  op = riscv_isa_pkg::alu_bne;
          riscv_isa_pkg::f3_blt:  op = riscv_isa_pkg::alu_blt;
          riscv_isa_pkg::f3_bge:  op = riscv_isa_pkg::alu_bge;
          riscv_isa_pkg::f3_bltu: op = riscv_isa_pkg::alu_bltu;
          riscv_isa_pkg::f3_bgeu: op = riscv_isa_pkg::alu_bgeu;
          default:                op = riscv_isa_pkg::alu_nop;
        endcase
      end
      riscv_isa_pkg::op_reg_imm: begin
        use_imm = 1'b1;
        writes  = 1'b1;
        // funct7 is immediate bits here except for shifts
        if (funct3 == riscv_isa_pkg::f3_add_sub) begin
          op = riscv_isa_pkg::alu_add;
        end else if (funct3 == riscv_isa_pkg::f3_sll || funct3 == riscv_isa_pkg::f3_srl_sra) begin
          op = funct7_ok ? arith_op : riscv_isa_pkg::alu_nop;
        end else begin
          op = arith_op;
        end
      end
      riscv_isa_pkg::op_reg_reg: begin
        op     = funct7_ok ? arith_op : riscv_isa_pkg::alu_nop;
        writes = 1'b1;
      end
      riscv_isa_pkg::op_environ: begin
        op = (d_insn[31:7] == '0) ? riscv_isa_pkg::alu_ecall : riscv_isa_pkg::alu_nop;
      end
      default: begin
        op = riscv_isa_pkg::alu_nop;
      end
    endcase
    // unknown encodings never write
    if (op == riscv_isa_pkg::alu_nop) begin
      writes = 1'b0;
    end
  end

  // control into execute, bubble on redirect
  always_ff @(posedge clk) begin
    if (rst || branch_taken) begin
      x_pc      <= '0;
      x_insn    <= '0;
      x_op      <= riscv_isa_pkg::alu_nop;
      x_use_imm <= 1'b0;
      x_we      <= 1'b0;
      x_status  <= rst ? pipe_pkg::cycle_reset : pipe_pkg::cycle_taken_branch;
    end else begin
      x_pc      <= d_pc;
      x_insn    <= d_insn;
      x_op      <= op;
      x_use_imm <= use_imm;
      x_we      <= writes && (rd != '0);
      x_status  <= d_status;
    end
  end

  // operands, with the writeback write seen in the same cycle
  always_ff @(posedge clk) begin
    x_rs1      <= rs1;
    x_rs2      <= rs2;
    x_rd       <= rd;
    x_rs1_data <= (w_we && w_rd == rs1) ? w_rd_data : rs1_data;
    x_rs2_data <= (w_we && w_rd == rs2) ? w_rd_data : rs2_data;
  end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  riscv_isa_pkg::word_t     x_pc,
  input  riscv_isa_pkg::insn_t     x_insn,
  input  riscv_isa_pkg::alu_op_t   x_op,
  input  logic                     x_use_imm,
  input  riscv_isa_pkg::reg_addr_t x_rs1,
  input  riscv_isa_pkg::reg_addr_t x_rs2,
  input  riscv_isa_pkg::reg_addr_t x_rd,
  input  logic                     x_we,
  input  riscv_isa_pkg::word_t     x_rs1_data,
  input  riscv_isa_pkg::word_t     x_rs2_data,
  input  pipe_pkg::cycle_status_t  x_status,
  input  riscv_isa_pkg::reg_addr_t w_rd,
  input  logic                     w_we,
  input  riscv_isa_pkg::word_t     w_rd_data,
  output logic                     branch_taken,
  output riscv_isa_pkg::word_t     branch_target,
  output riscv_isa_pkg::word_t     m_pc,
  output riscv_isa_pkg::insn_t     m_insn,
  output riscv_isa_pkg::reg_addr_t m_rd,
  output logic                     m_we,
  output riscv_isa_pkg::word_t     m_rd_data,
  output logic                     m_halt,
  output pipe_pkg::cycle_status_t  m_status
);

  riscv_isa_pkg::word_t opa;
  riscv_isa_pkg::word_t rs2_val;
  riscv_isa_pkg::word_t opb;
  riscv_isa_pkg::word_t imm_i;
  riscv_isa_pkg::word_t imm_b;
  riscv_isa_pkg::word_t imm_j;
  riscv_isa_pkg::word_t imm_u;
  riscv_isa_pkg::word_t link;
  riscv_isa_pkg::word_t jalr_sum;
  riscv_isa_pkg::word_t result;
  logic                 halt_x;

  // memory stage first since it is younger, branches carry we low
  always_comb begin
    if (m_we && m_rd == x_rs1) begin
      opa = m_rd_data;
    end else if (w_we && w_rd == x_rs1) begin
      opa = w_rd_data;
    end else begin
      opa = x_rs1_data;
    end
    if (m_we && m_rd == x_rs2) begin
      rs2_val = m_rd_data;
    end else if (w_we && w_rd == x_rs2) begin
      rs2_val = w_rd_data;
    end else begin
      rs2_val = x_rs2_data;
    end
  end

  assign imm_i = {{20{x_insn[31]}}, x_insn[31:20]};
  assign imm_b = {{19{x_insn[31]}}, x_insn[31], x_insn[7], x_insn[30:25], x_insn[11:8], 1'b0};
  assign imm_j = {{11{x_insn[31]}}, x_insn[31], x_insn[19:12], x_insn[20], x_insn[30:21], 1'b0};
  assign imm_u = {x_insn[31:12], 12'b0};

  assign opb      = x_use_imm ? imm_i : rs2_val;
  assign link     = x_pc + pipe_pkg::insn_bytes;
  assign jalr_sum = opa + imm_i;

  always_comb begin
    result        = '0;
    halt_x        = 1'b0;
    branch_taken  = 1'b0;
    branch_target = x_pc + imm_b;
    case (x_op)
      riscv_isa_pkg::alu_add:  result = opa + opb;
      riscv_isa_pkg::alu_sub:  result = opa - opb;
      riscv_isa_pkg::alu_sll:  result = opa << opb[4:0];
      riscv_isa_pkg::alu_slt:  result = {31'b0, $signed(opa) < $signed(opb)};
      riscv_isa_pkg::alu_sltu: result = {31'b0, opa < opb};
      riscv_isa_pkg::alu_xor:  result = opa ^ opb;
      riscv_isa_pkg::alu_srl:  result = opa >> opb[4:0];
      riscv_isa_pkg::alu_sra:  result = $signed(opa) >>> opb[4:0];
      riscv_isa_pkg::alu_or:   result = opa | opb;
      riscv_isa_pkg::alu_and:  result = opa & opb;
      riscv_isa_pkg::alu_lui:  result = imm_u;
      riscv_isa_pkg::alu_jal: begin
        result        = link;
        branch_taken  = 1'b1;
        branch_target = x_pc + imm_j;
      end
      riscv_isa_pkg::alu_jalr: begin
        result        = link;
        branch_taken  = 1'b1;
        branch_target = {jalr_sum[31:1], 1'b0};
      end
      riscv_isa_pkg::alu_beq:   branch_taken = (opa == rs2_val);
      riscv_isa_pkg::alu_bne:   branch_taken = (opa != rs2_val);
      riscv_isa_pkg::alu_blt:   branch_taken = $signed(opa) < $signed(rs2_val);
      riscv_isa_pkg::alu_bge:   branch_taken = $signed(opa) >= $signed(rs2_val);
      riscv_isa_pkg::alu_bltu:  branch_taken = opa < rs2_val;
      riscv_isa_pkg::alu_bgeu:  branch_taken = opa >= rs2_val;
      riscv_isa_pkg::alu_ecall: halt_x = 1'b1;
      default: begin
        result = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_we     <= 1'b0;
      m_halt   <= 1'b0;
      m_status <= pipe_pkg::cycle_reset;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_we     <= x_we;
      m_halt   <= halt_x;
      m_status <= x_status;
    end
  end

  always_ff @(posedge clk) begin
    m_rd      <= x_rd;
    m_rd_data <= result;
  end

endmodule

// File: retire_stages.sv
`timescale 1ns/1ps

module retire_stages (
  input  logic                     clk,
  input  logic                     rst,
  input  riscv_isa_pkg::word_t     m_pc,
  input  riscv_isa_pkg::insn_t     m_insn,
  input  riscv_isa_pkg::reg_addr_t m_rd,
  input  logic                     m_we,
  input  riscv_isa_pkg::word_t     m_rd_data,
  input  logic                     m_halt,
  input  pipe_pkg::cycle_status_t  m_status,
  output riscv_isa_pkg::reg_addr_t w_rd,
  output logic                     w_we,
  output riscv_isa_pkg::word_t     w_rd_data,
  output logic                     halt,
  output riscv_isa_pkg::word_t     trace_writeback_pc,
  output riscv_isa_pkg::insn_t     trace_writeback_insn,
  output pipe_pkg::cycle_status_t  trace_writeback_cycle_status,
  output riscv_isa_pkg::reg_addr_t trace_writeback_rd,
  output logic                     trace_writeback_we,
  output riscv_isa_pkg::word_t     trace_writeback_rd_data
);

  // no memory access, the memory stage only hands its register on
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_writeback_pc           <= '0;
      trace_writeback_insn         <= '0;
      trace_writeback_cycle_status <= pipe_pkg::cycle_reset;
      w_we                         <= 1'b0;
      halt                         <= 1'b0;
    end else begin
      trace_writeback_pc           <= m_pc;
      trace_writeback_insn         <= m_insn;
      trace_writeback_cycle_status <= m_status;
      w_we                         <= m_we;
      halt                         <= m_halt;
    end
  end

  always_ff @(posedge clk) begin
    w_rd      <= m_rd;
    w_rd_data <= m_rd_data;
  end

  // the retiring write is what the trace shows
  assign trace_writeback_rd      = w_rd;
  assign trace_writeback_we      = w_we;
  assign trace_writeback_rd_data = w_rd_data;

endmodule

// File: rv_pipeline.sv
`timescale 1ns/1ps

module rv_pipeline #(
  parameter riscv_isa_pkg::word_t reset_pc = 32'd0
) (
  input  logic                     clk,
  input  logic                     rst,
  output riscv_isa_pkg::word_t     pc_to_imem,
  input  riscv_isa_pkg::insn_t     insn_from_imem,
  output logic                     halt,
  output riscv_isa_pkg::word_t     trace_writeback_pc,
  output riscv_isa_pkg::insn_t     trace_writeback_insn,
  output pipe_pkg::cycle_status_t  trace_writeback_cycle_status,
  output riscv_isa_pkg::reg_addr_t trace_writeback_rd,
  output logic                     trace_writeback_we,
  output riscv_isa_pkg::word_t     trace_writeback_rd_data
);

  logic                     branch_taken;
  riscv_isa_pkg::word_t     branch_target;
  riscv_isa_pkg::word_t     d_pc;
  riscv_isa_pkg::insn_t     d_insn;
  pipe_pkg::cycle_status_t  d_status;
  riscv_isa_pkg::reg_addr_t rs1;
  riscv_isa_pkg::reg_addr_t rs2;
  riscv_isa_pkg::word_t     rs1_data;
  riscv_isa_pkg::word_t     rs2_data;
  riscv_isa_pkg::word_t     x_pc;
  riscv_isa_pkg::insn_t     x_insn;
  riscv_isa_pkg::alu_op_t   x_op;
  logic                     x_use_imm;
  riscv_isa_pkg::reg_addr_t x_rs1;
  riscv_isa_pkg::reg_addr_t x_rs2;
  riscv_isa_pkg::reg_addr_t x_rd;
  logic                     x_we;
  riscv_isa_pkg::word_t     x_rs1_data;
  riscv_isa_pkg::word_t     x_rs2_data;
  pipe_pkg::cycle_status_t  x_status;
  riscv_isa_pkg::word_t     m_pc;
  riscv_isa_pkg::insn_t     m_insn;
  riscv_isa_pkg::reg_addr_t m_rd;
  logic                     m_we;
  riscv_isa_pkg::word_t     m_rd_data;
  logic                     m_halt;
  pipe_pkg::cycle_status_t  m_status;
  riscv_isa_pkg::reg_addr_t w_rd;
  logic                     w_we;
  riscv_isa_pkg::word_t     w_rd_data;

  fetch_stage #(
    .reset_pc(reset_pc)
  ) fetch (
    .clk(clk), .rst(rst), .branch_taken(branch_taken), .branch_target(branch_target),
    .insn_from_imem(insn_from_imem), .pc_to_imem(pc_to_imem),
    .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status)
  );

  decode_stage decode (
    .clk(clk), .rst(rst), .branch_taken(branch_taken),
    .d_pc(d_pc), .d_insn(d_insn), .d_status(d_status),
    .w_rd(w_rd), .w_we(w_we), .w_rd_data(w_rd_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .x_pc(x_pc), .x_insn(x_insn), .x_op(x_op), .x_use_imm(x_use_imm),
    .x_rs1(x_rs1), .x_rs2(x_rs2), .x_rd(x_rd), .x_we(x_we),
    .x_rs1_data(x_rs1_data), .x_rs2_data(x_rs2_data), .x_status(x_status)
  );

  reg_file rf (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(w_rd), .we(w_we),
    .rd_data(w_rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  execute_stage execute (
    .clk(clk), .rst(rst),
    .x_pc(x_pc), .x_insn(x_insn), .x_op(x_op), .x_use_imm(x_use_imm),
    .x_rs1(x_rs1), .x_rs2(x_rs2), .x_rd(x_rd), .x_we(x_we),
    .x_rs1_data(x_rs1_data), .x_rs2_data(x_rs2_data), .x_status(x_status),
    .w_rd(w_rd), .w_we(w_we), .w_rd_data(w_rd_data),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .m_pc(m_pc), .m_insn(m_insn), .m_rd(m_rd), .m_we(m_we),
    .m_rd_data(m_rd_data), .m_halt(m_halt), .m_status(m_status)
  );

  retire_stages retire (
    .clk(clk), .rst(rst),
    .m_pc(m_pc), .m_insn(m_insn), .m_rd(m_rd), .m_we(m_we),
    .m_rd_data(m_rd_data), .m_halt(m_halt), .m_status(m_status),
    .w_rd(w_rd), .w_we(w_we), .w_rd_data(w_rd_data), .halt(halt),
    .trace_writeback_pc(trace_writeback_pc),
    .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_rd(trace_writeback_rd),
    .trace_writeback_we(trace_writeback_we),
    .trace_writeback_rd_data(trace_writeback_rd_data)
  );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // two rising edges in reset, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: rv_pipeline_asserts.sv
`timescale 1ns/1ps

module rv_pipeline_asserts (
  input logic                     clk,
  input logic                     rst,
  input logic                     halt,
  input riscv_isa_pkg::word_t     pc,
  input riscv_isa_pkg::insn_t     insn,
  input pipe_pkg::cycle_status_t  status,
  input riscv_isa_pkg::reg_addr_t rd,
  input logic                     we,
  input riscv_isa_pkg::word_t     rd_data
);

  logic                 retired;
  riscv_isa_pkg::word_t last_pc;
  riscv_isa_pkg::word_t next_pc;
  logic [1:0]           bubbles;
  logic [1:0]           want_bubbles;
  logic                 no_stall;
  logic                 is_jump;

  assign no_stall = (status == pipe_pkg::cycle_no_stall);
  assign is_jump  = (insn[6:0] == riscv_isa_pkg::op_jal) || (insn[6:0] == riscv_isa_pkg::op_jalr);
  assign next_pc  = rv_pipeline_tb.expected_next_pc[last_pc[7:2]];
  // a redirect always costs two flushed slots
  assign want_bubbles = (next_pc != last_pc + 32'd4) ? 2'd2 : 2'd0;

  // last retired pc and the flushed slots since
  always_ff @(posedge clk) begin
    if (rst) begin
      retired <= 1'b0;
      last_pc <= '0;
      bubbles <= '0;
    end else if (no_stall) begin
      retired <= 1'b1;
      last_pc <= pc;
      bubbles <= '0;
    end else if (status == pipe_pkg::cycle_taken_branch && bubbles != 2'd3) begin
      bubbles <= bubbles + 2'd1;
    end
  end

  reset_state: assert property (@(posedge clk) rst |=> (status == pipe_pkg::cycle_reset))
    else begin
      $error("writeback status did not show reset after reset");
      rv_pipeline_tb.fail_count++;
    end

  // reset status drains from the earlier stages until the first retirement
  reset_hold: assert property (@(posedge clk) disable iff (rst)
      (!retired && !no_stall) |-> (status == pipe_pkg::cycle_reset))
    else begin
      $error("writeback status left reset before the first instruction retired");
      rv_pipeline_tb.fail_count++;
    end

  reset_quiet: assert property (@(posedge clk) disable iff (rst)
      (status == pipe_pkg::cycle_reset) |-> (!we && !halt))
    else begin
      $error("write enable or halt high while writeback still in reset");
      rv_pipeline_tb.fail_count++;
    end

  rd_value: assert property (@(posedge clk) disable iff (rst)
      (no_stall && we) |-> (rd_data == rv_pipeline_tb.expected_rd_data[pc[7:2]]))
    else begin
      $error("Error %s: pc %h expected %h actual %h", rv_pipeline_tb.test_name, pc,
             rv_pipeline_tb.expected_rd_data[pc[7:2]], rd_data);
      rv_pipeline_tb.fail_count++;
    end

  link_value: assert property (@(posedge clk) disable iff (rst)
      (no_stall && is_jump) |-> (rd_data == pc + 32'd4))
    else begin
      $error("Error %s: link expected %h actual %h", rv_pipeline_tb.test_name, pc + 32'd4,
             rd_data);
      rv_pipeline_tb.fail_count++;
    end

  // covers targets, not-taken fall through and the bubble count
  pc_flow: assert property (@(posedge clk) disable iff (rst)
      (no_stall && retired) |-> (pc == next_pc && bubbles == want_bubbles))
    else begin
      $error("Error %s: next pc expected %h actual %h, flushed slots expected %0d actual %0d",
             rv_pipeline_tb.test_name, next_pc, pc, want_bubbles, bubbles);
      rv_pipeline_tb.fail_count++;
    end

  bubble_empty: assert property (@(posedge clk) disable iff (rst)
      (status == pipe_pkg::cycle_taken_branch) |-> (pc == '0 && insn == '0 && !we))
    else begin
      $error("flushed slot in writeback carries a pc, an instruction or a write");
      rv_pipeline_tb.fail_count++;
    end

  branch_no_write: assert property (@(posedge clk) disable iff (rst)
      (no_stall && insn[6:0] == riscv_isa_pkg::op_branch) |-> !we)
    else begin
      $error("conditional branch retired with a register write");
      rv_pipeline_tb.fail_count++;
    end

  no_x0_write: assert property (@(posedge clk) disable iff (rst) we |-> (rd != '0))
    else begin
      $error("a retirement wrote register x0");
      rv_pipeline_tb.fail_count++;
    end

  halt_on_ecall: assert property (@(posedge clk) disable iff (rst)
      halt == (no_stall && insn == 32'h0000_0073))
    else begin
      $error("halt does not match an ecall in writeback");
      rv_pipeline_tb.fail_count++;
    end

endmodule

// File: rv_pipeline_tb.sv
`timescale 1ns/1ps

module rv_pipeline_tb;

  localparam int prog_len = 47;
  localparam int timeout_cycles = 200;

  logic                     clk;
  logic                     rst;
  riscv_isa_pkg::word_t     pc_to_imem;
  riscv_isa_pkg::insn_t     insn_from_imem;
  logic                     halt;
  riscv_isa_pkg::word_t     trace_writeback_pc;
  riscv_isa_pkg::insn_t     trace_writeback_insn;
  pipe_pkg::cycle_status_t  trace_writeback_cycle_status;
  riscv_isa_pkg::reg_addr_t trace_writeback_rd;
  logic                     trace_writeback_we;
  riscv_isa_pkg::word_t     trace_writeback_rd_data;

  riscv_isa_pkg::insn_t prog [0:63];
  riscv_isa_pkg::word_t expected_rd_data [0:63];
  riscv_isa_pkg::word_t expected_next_pc [0:63];
  string                test_name;
  int                   fail_count;
  int                   tests_run;
  logic                 aborted;

  tb_clock_gen clkgen (.clk(clk), .rst(rst));

  rv_pipeline #(.reset_pc(32'd0)) dut0 (
    .clk(clk), .rst(rst), .pc_to_imem(pc_to_imem), .insn_from_imem(insn_from_imem),
    .halt(halt), .trace_writeback_pc(trace_writeback_pc),
    .trace_writeback_insn(trace_writeback_insn),
    .trace_writeback_cycle_status(trace_writeback_cycle_status),
    .trace_writeback_rd(trace_writeback_rd), .trace_writeback_we(trace_writeback_we),
    .trace_writeback_rd_data(trace_writeback_rd_data)
  );

  bind rv_pipeline rv_pipeline_asserts checks (
    .clk(clk), .rst(rst), .halt(halt), .pc(trace_writeback_pc),
    .insn(trace_writeback_insn), .status(trace_writeback_cycle_status),
    .rd(trace_writeback_rd), .we(trace_writeback_we), .rd_data(trace_writeback_rd_data)
  );

  task automatic put(input int idx, input riscv_isa_pkg::insn_t insn,
                     input riscv_isa_pkg::word_t value);
    prog[idx] = insn;
    expected_rd_data[idx] = value;
  endtask

  // nop outside the program
  function automatic riscv_isa_pkg::insn_t imem_word(input riscv_isa_pkg::word_t addr);
    if (addr[1:0] == 2'b00 && addr < prog_len * 4) begin
      return prog[addr[7:2]];
    end
    return 32'h0000_0013;
  endfunction

  always @(negedge clk) begin
    insn_from_imem <= imem_word(pc_to_imem);
  end

  task automatic load_program;
    for (int i = 0; i < 64; i++) begin
      prog[i] = 32'h0000_0013;
      expected_rd_data[i] = '0;
      expected_next_pc[i] = 32'(i * 4 + 4);
    end
    put(0, 32'h0050_0093, 32'h0000_0005);  // addi x1,x0,5
    put(1, 32'hffd0_0113, 32'hffff_fffd);  // addi x2,x0,-3
    put(2, 32'h0001_2193, 32'h0000_0001);  // slti x3,x2,0
    put(3, 32'h0051_3213, 32'h0000_0000);  // sltiu x4,x2,5
    put(4, 32'h00f0_c293, 32'h0000_000a);  // xori x5,x1,15
    put(5, 32'h0300_e313, 32'h0000_0035);  // ori x6,x1,0x30
    put(6, 32'h0ff1_7393, 32'h0000_00fd);  // andi x7,x2,0xff
    put(7, 32'h0040_9413, 32'h0000_0050);  // slli x8,x1,4
    put(8, 32'h01c1_5493, 32'h0000_000f);  // srli x9,x2,28
    put(9, 32'h4011_5513, 32'hffff_fffe);  // srai x10,x2,1
    put(10, 32'h0050_85b3, 32'h0000_000f); // add x11,x1,x5
    put(11, 32'h4020_8633, 32'h0000_0008); // sub x12,x1,x2
    put(12, 32'h0010_96b3, 32'h0000_00a0); // sll x13,x1,x1
    put(13, 32'h0011_2733, 32'h0000_0001); // slt x14,x2,x1
    put(14, 32'h0011_37b3, 32'h0000_0000); // sltu x15,x2,x1
    put(15, 32'h0062_c833, 32'h0000_003f); // xor x16,x5,x6
    put(16, 32'h0011_58b3, 32'h07ff_ffff); // srl x17,x2,x1
    put(17, 32'h4011_5933, 32'hffff_ffff); // sra x18,x2,x1
    put(18, 32'h0062_e9b3, 32'h0000_003f); // or x19,x5,x6
    put(19, 32'h0073_7a33, 32'h0000_0035); // and x20,x6,x7
    put(20, 32'h1234_5ab7, 32'h1234_5000); // lui x21,0x12345
    put(21, 32'h0070_0b13, 32'h0000_0007); // addi x22,x0,7
    put(22, 32'h001b_0b93, 32'h0000_0008); // addi x23,x22,1, distance 1
    put(23, 32'h016b_8c33, 32'h0000_000f); // add x24,x23,x22, distances 1 and 2
    put(24, 32'h0010_0c93, 32'h0000_0001); // addi x25,x0,1
    put(25, 32'h017c_0d33, 32'h0000_0017); // add x26,x24,x23, distances 2 and 3
    put(26, 32'h419d_0db3, 32'h0000_0016); // sub x27,x26,x25
    put(27, 32'h00c0_0e6f, 32'h0000_0070); // jal x28,+12
    put(28, 32'h0010_0e93, 32'h0000_0000); // flushed
    put(29, 32'h0020_0e93, 32'h0000_0000); // flushed
    put(30, 32'h0010_8663, 32'h0000_0000); // beq x1,x1,+12
    put(31, 32'h0030_0e93, 32'h0000_0000); // flushed
    put(32, 32'h0040_0e93, 32'h0000_0000); // flushed
    put(33, 32'h0940_0e93, 32'h0000_0094); // addi x29,x0,0x94
    put(34, 32'h004e_8f67, 32'h0000_008c); // jalr x30,4(x29)
    put(35, 32'h0050_0e93, 32'h0000_0000); // flushed
    put(36, 32'h0060_0e93, 32'h0000_0000); // flushed
    put(37, 32'h0070_0e93, 32'h0000_0000); // never fetched
    put(38, 32'h0090_0f93, 32'h0000_0009); // addi x31,x0,9
    put(39, 32'h0010_9463, 32'h0000_0000); // bne x1,x1,+8 falls through
    put(40, 32'h0050_8013, 32'h0000_0000); // addi x0,x1,5, no write
    put(41, 32'h0020_c463, 32'h0000_0000); // blt x1,x2,+8 falls through
    put(42, 32'h0000_01b3, 32'h0000_0000); // add x3,x0,x0
    put(43, 32'h0011_6463, 32'h0000_0000); // bltu x2,x1,+8 falls through
    put(44, 32'h07f0_0213, 32'h0000_007f); // addi x4,x0,0x7f
    put(45, 32'h0012_8293, 32'h0000_000b); // addi x5,x5,1
    put(46, 32'h0000_0073, 32'h0000_0000); // ecall
    expected_next_pc[27] = 32'h0000_0078;
    expected_next_pc[30] = 32'h0000_0084;
    expected_next_pc[34] = 32'h0000_0098;
  endtask

  // marker pc must retire in writeback
  task automatic run_test(input string name, input riscv_isa_pkg::word_t marker);
    int cycles;
    int fails_before;
    if (aborted) begin
      return;
    end
    test_name = name;
    fails_before = fail_count;
    cycles = 0;
    while (!(trace_writeback_pc == marker &&
             trace_writeback_cycle_status == pipe_pkg::cycle_no_stall)) begin
      if (cycles == timeout_cycles) begin
        $display("test %s timed out waiting for pc %h in writeback", name, marker);
        fail_count++;
        aborted = 1'b1;
        return;
      end
      @(negedge clk);
      cycles++;
    end
    tests_run++;
    $display("test %s finished with %0d failures", name, fail_count - fails_before);
  endtask

  initial begin
    int cycles;
    insn_from_imem = 32'h0000_0013;
    fail_count = 0;
    tests_run = 0;
    aborted = 1'b0;
    test_name = "reset";
    load_program();
    cycles = 0;
    @(negedge clk);
    while (rst && !aborted) begin
      if (cycles == 10) begin
        $display("reset was never released");
        fail_count++;
        aborted = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    run_test("reset", 32'h0000_0000);
    run_test("alu", 32'h0000_0050);
    run_test("bypass", 32'h0000_0068);
    run_test("control", 32'h0000_0098);
    run_test("not_taken_x0", 32'h0000_00b0);
    run_test("halt", 32'h0000_00b8);
    // let the last retirements reach the checkers
    repeat (3) @(negedge clk);
    $display("tests run %0d of 6, failures %0d", tests_run, fail_count);
    if (fail_count == 0 && !aborted) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: rv_pipeline.f
riscv_isa_pkg.sv
pipe_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
retire_stages.sv
rv_pipeline.sv
tb_clock_gen.sv
rv_pipeline_asserts.sv
rv_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= rv_pipeline_tb
FILELIST ?= rv_pipeline.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
